/* compile.f */
jtag_bridge_pkg.sv
bit_synchronizer.sv
control_signal_crosser.sv
source_crosser.sv
sink_crosser.sv
jtag_streaming.sv
jtag_dc_streaming.sv
tb_jtag_dc_streaming.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the jtag bridge testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
   --top-module tb_jtag_dc_streaming -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q '^RESULT: PASS$'; then
   exit 0
fi
exit 1

/* tb_jtag_dc_streaming.sv */
// jtag bridge testbench
`default_nettype none

module tb_jtag_dc_streaming
   import jtag_bridge_pkg::*;
;

   localparam int clk_period  = 100;
   localparam int tck_period  = 370;
   localparam int frame_tck   = frame_bits + 2; // driver edges per frame, tdo drains 2 late
   localparam int cycle_limit = (40 * frame_bits * tck_period) / clk_period + 300;

   logic                  clk;
   logic                  tck;
   logic                  reset_n;
   logic                  tdi;
   logic                  shift_en;
   logic                  tdo;
   logic [byte_width-1:0] source_data;
   logic                  source_valid;
   logic [byte_width-1:0] sink_data;
   logic                  sink_valid;
   logic                  sink_ready;
   logic                  resetrequest;

   int                    error_count   = 0;
   int                    check_count   = 0;
   int                    cycle_count   = 0;
   int                    source_pulses = 0;
   int                    reset_pulses  = 0;
   int                    test_errors   = 0; // error_count when the test began
   logic [31:0]           rng_state     = 32'd82768;
   logic [byte_width-1:0] expect_q[$];       // bytes still owed on source_data
   string                 test_name     = "none";

   jtag_dc_streaming u_jtag_dc_streaming (
      .clk          (clk),
      .reset_n      (reset_n),
      .tck          (tck),
      .tdi          (tdi),
      .shift_en     (shift_en),
      .tdo          (tdo),
      .source_data  (source_data),
      .source_valid (source_valid),
      .sink_data    (sink_data),
      .sink_valid   (sink_valid),
      .sink_ready   (sink_ready),
      .resetrequest (resetrequest)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      tck = 1'b0;
      forever #(tck_period / 2) tck = ~tck; // unrelated to clk
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic next_byte(output logic [byte_width-1:0] value);
      rng_state = lcg_next(rng_state);
      value     = rng_state[23:16]; // upper bits mix better
   endtask

   task automatic check_equal(input string name, input int expected, input int actual);
      check_count++;
      assert (expected == actual) else begin
         error_count++;
         $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = error_count;
   endtask

   task automatic end_test();
      if (error_count == test_errors) $display("test %s: ok", test_name);
      else $display("test %s: %0d errors", test_name, error_count - test_errors);
   endtask

   // one 9-bit frame in on tdi, one frame captured from tdo
   task automatic shift_frame(input logic flag, input logic [byte_width-1:0] data,
                              output logic out_flag, output logic [byte_width-1:0] out_data);
      logic [frame_bits-1:0] tx_bits;
      logic [frame_bits-1:0] rx_bits;
      tx_bits = {data, flag}; // flag leads, then data lsb first
      rx_bits = '0;
      for (int i = 0; i < frame_tck; i++) begin
         @(posedge tck);
         if (i >= 2) rx_bits[i-2] = tdo; // bit shown after the edge that shifted it
         if (i < frame_bits) begin
            tdi      <= tx_bits[i];
            shift_en <= 1'b1;
         end else begin
            tdi      <= 1'b0;
            shift_en <= 1'b0;
         end
      end
      out_flag = rx_bits[0];
      out_data = rx_bits[frame_bits-1:1];
   endtask

   task automatic send_sink_byte(input logic [byte_width-1:0] value);
      @(negedge clk);
      check_count++;
      assert (sink_ready) else begin
         error_count++;
         $display("sink_ready was low when a new byte was due in test %s", test_name);
      end
      @(posedge clk);
      sink_data  <= value;
      sink_valid <= 1'b1;
      @(posedge clk); // accepted here
      sink_valid <= 1'b0;
      @(negedge clk);
      check_equal({test_name, " sink_ready after accept"}, 0, int'(sink_ready));
   endtask

   // scoreboard for the tck to clk path
   always @(negedge clk) begin
      if (reset_n && source_valid) begin
         source_pulses++;
         check_count++;
         assert (expect_q.size() > 0) else begin
            error_count++;
            $display("source_valid pulsed with no byte expected in test %s", test_name);
         end
         if (expect_q.size() > 0) check_equal(test_name, int'(expect_q.pop_front()),
                                              int'(source_data));
      end
      if (reset_n && resetrequest) reset_pulses++;
   end

   a_ready_drops: assert property (@(posedge clk) disable iff (!reset_n)
      (sink_valid && sink_ready) |=> !sink_ready)
      else begin
         error_count++;
         $display("sink_ready stayed high after a byte was accepted");
      end

   a_reset_single: assert property (@(posedge clk) disable iff (!reset_n)
      resetrequest |=> !resetrequest)
      else begin
         error_count++;
         $display("resetrequest was high for more than one clk cycle");
      end

   // run limit from 40 frames of tck time plus margin
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d clk cycles in test %s", cycle_count, test_name);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      logic                  flag;
      logic [byte_width-1:0] data;
      logic [byte_width-1:0] value;
      int                    base;
      int                    reset_base;
      int                    frames;
      int                    waited;
      reset_n    = 1'b0;
      tdi        = 1'b0;
      shift_en   = 1'b0;
      sink_data  = '0;
      sink_valid = 1'b0;
      repeat (2) @(posedge clk);
      reset_n <= 1'b1;
      repeat (3) @(posedge tck); // tck reset release

      start_test("after_reset");
      @(negedge clk);
      check_equal({test_name, " source_valid"}, 0, int'(source_valid));
      check_equal({test_name, " resetrequest"}, 0, int'(resetrequest));
      check_equal({test_name, " tdo"}, 0, int'(tdo));
      check_equal({test_name, " sink_ready"}, 1, int'(sink_ready));
      end_test();

      start_test("rx_bytes");
      base = source_pulses;
      for (int n = 0; n < 8; n++) begin
         next_byte(value);
         if (value == reset_cmd_byte) value = value ^ 8'h01; // keep it a data byte
         expect_q.push_back(value);
         shift_frame(1'b1, value, flag, data);
         check_equal({test_name, " idle tdo flag"}, 0, int'(flag));
      end
      while (expect_q.size() > 0) @(negedge clk); // timeout guards this
      check_equal({test_name, " pulse count"}, 8, source_pulses - base);
      end_test();

      start_test("rx_flag_zero");
      base = source_pulses;
      shift_frame(1'b0, 8'h5A, flag, data);
      repeat (12) @(negedge clk); // well past the crossing latency
      check_equal({test_name, " pulse count"}, base, source_pulses);
      end_test();

      start_test("reset_command");
      base       = source_pulses;
      reset_base = reset_pulses;
      shift_frame(1'b1, reset_cmd_byte, flag, data);
      repeat (12) @(negedge clk);
      check_equal({test_name, " resetrequest pulses"}, 1, reset_pulses - reset_base);
      check_equal({test_name, " source pulses"}, base, source_pulses);
      end_test();

      start_test("tx_bytes");
      for (int n = 0; n < 4; n++) begin
         next_byte(value);
         send_sink_byte(value);
         frames = 0;
         flag   = 1'b0;
         while (!flag && frames < 4) begin // empty frames until the byte shows up
            shift_frame(1'b0, 8'h00, flag, data);
            frames++;
            if (!flag) check_equal({test_name, " empty frame data"}, 0, int'(data));
         end
         check_equal({test_name, " tdo flag"}, 1, int'(flag));
         check_equal({test_name, " tdo data"}, int'(value), int'(data));
         waited = 0;
         while (!sink_ready && waited < 20) begin
            @(negedge clk);
            waited++;
         end
         check_equal({test_name, " sink_ready back"}, 1, int'(sink_ready));
      end
      end_test();

      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) $display("RESULT: PASS");
      else $display("RESULT: FAIL");
      $finish;
   end

endmodule : tb_jtag_dc_streaming

`default_nettype wire

/* jtag_dc_streaming.sv */
// jtag byte stream bridge top
`default_nettype none

module jtag_dc_streaming
   import jtag_bridge_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset_n,
   input  wire                   tck,
   input  wire                   tdi,
   input  wire                   shift_en,
   output logic                  tdo,
   output logic [byte_width-1:0] source_data,
   output logic                  source_valid,
   input  wire  [byte_width-1:0] sink_data,
   input  wire                   sink_valid,
   output logic                  sink_ready,
   output logic                  resetrequest
);

   logic                  tck_reset_n; // async assert, tck synchronous release
   logic [byte_width-1:0] rx_byte;
   logic                  rx_strobe;
   logic [byte_width-1:0] tx_byte;
   logic                  tx_pending;
   logic                  tx_taken;
   logic                  reset_level;

   bit_synchronizer #(.depth(clk_to_tck_sync_depth)) u_tck_reset_sync (
      .clk     (tck),
      .reset_n (reset_n),
      .din     (1'b1),
      .dout    (tck_reset_n)
   );

   jtag_streaming u_jtag_streaming (
      .tck         (tck),
      .reset_n     (tck_reset_n),
      .tdi         (tdi),
      .shift_en    (shift_en),
      .tdo         (tdo),
      .rx_byte     (rx_byte),
      .rx_strobe   (rx_strobe),
      .tx_byte     (tx_byte),
      .tx_pending  (tx_pending),
      .tx_taken    (tx_taken),
      .reset_level (reset_level)
   );

   source_crosser #(.sync_depth(tck_to_clk_sync_depth)) u_source_crosser (
      .tck          (tck),
      .tck_reset_n  (tck_reset_n),
      .rx_byte      (rx_byte),
      .rx_strobe    (rx_strobe),
      .clk          (clk),
      .reset_n      (reset_n),
      .source_data  (source_data),
      .source_valid (source_valid)
   );

   sink_crosser #(
      .req_sync_depth (clk_to_tck_sync_depth),
      .ack_sync_depth (tck_to_clk_sync_depth)
   ) u_sink_crosser (
      .clk         (clk),
      .reset_n     (reset_n),
      .sink_data   (sink_data),
      .sink_valid  (sink_valid),
      .sink_ready  (sink_ready),
      .tck         (tck),
      .tck_reset_n (tck_reset_n),
      .tx_byte     (tx_byte),
      .tx_pending  (tx_pending),
      .tx_taken    (tx_taken)
   );

   // each command toggles reset_level once
   control_signal_crosser #(
      .sync_depth (tck_to_clk_sync_depth),
      .edge_mode  (edge_any)
   ) u_reset_crosser (
      .clk         (clk),
      .reset_n     (reset_n),
      .async_level (reset_level),
      .pulse       (resetrequest)
   );

endmodule : jtag_dc_streaming

`default_nettype wire

/* jtag_streaming.sv */
// tck frame engine
`default_nettype none

module jtag_streaming
   import jtag_bridge_pkg::*;
(
   input  wire                   tck,
   input  wire                   reset_n,     // already synchronous to tck
   input  wire                   tdi,
   input  wire                   shift_en,    // one bit per tck while high
   output logic                  tdo,
   output logic [byte_width-1:0] rx_byte,
   output logic                  rx_strobe,   // one tck, flagged non-command byte
   input  wire  [byte_width-1:0] tx_byte,
   input  wire                   tx_pending,
   output logic                  tx_taken,    // one tck, byte loaded at frame start
   output logic                  reset_level  // toggles per reset command
);

   frame_phase_t               phase;
   logic [frame_cnt_width-1:0] bit_cnt;  // shift position in frame
   logic                       rx_flag;  // flag of the frame in flight
   logic [byte_width-1:0]      rx_shift; // lsb arrives first
   logic [byte_width-1:0]      rx_next;
   logic [byte_width-1:0]      tx_shift;
   logic                       tx_bit;   // next bit for tdo
   logic                       frame_start;
   logic                       frame_end;

   assign frame_start = shift_en && (phase == phase_flag);
   assign frame_end   = shift_en && (bit_cnt == frame_cnt_width'(frame_bits - 1));
   assign rx_next     = {tdi, rx_shift[byte_width-1:1]};
   assign tx_taken    = frame_start & tx_pending;
   assign rx_byte     = rx_shift; // untouched until next data shift

   // control state
   always_ff @(posedge tck or negedge reset_n) begin
      if (!reset_n) begin
         phase       <= phase_flag;
         bit_cnt     <= '0;
         rx_flag     <= 1'b0;
         rx_strobe   <= 1'b0;
         reset_level <= 1'b0;
         tx_bit      <= 1'b0;
      end else begin
         rx_strobe <= 1'b0; // default
         if (frame_start) begin
            phase   <= phase_data;
            bit_cnt <= frame_cnt_width'(1);
            rx_flag <= tdi;
            tx_bit  <= tx_pending; // flag goes out first
         end else if (shift_en) begin
            tx_bit <= tx_shift[0];
            if (frame_end) begin
               phase   <= phase_flag;
               bit_cnt <= '0;
               if (rx_flag && (rx_next == reset_cmd_byte)) reset_level <= ~reset_level;
               else if (rx_flag)                           rx_strobe   <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   // shift registers
   always_ff @(posedge tck) begin
      if (frame_start) begin
         tx_shift <= tx_pending ? tx_byte : '0; // empty frame sends zeros
      end else if (shift_en) begin
         tx_shift <= tx_shift >> 1;
         rx_shift <= rx_next;
      end
   end

   // tdo moves on the falling edge, stable for the next rising sample
   always_ff @(negedge tck or negedge reset_n) begin
      if (!reset_n) tdo <= 1'b0;
      else          tdo <= tx_bit;
   end

endmodule : jtag_streaming

`default_nettype wire

/* sink_crosser.sv */
// clk to tck byte crosser
`default_nettype none

module sink_crosser
   import jtag_bridge_pkg::*;
#(
   parameter int req_sync_depth = clk_to_tck_sync_depth, // req into tck
   parameter int ack_sync_depth = tck_to_clk_sync_depth  // ack back into clk
) (
   // clk side
   input  wire                   clk,
   input  wire                   reset_n,
   input  wire  [byte_width-1:0] sink_data,
   input  wire                   sink_valid,
   output logic                  sink_ready,
   // tck side
   input  wire                   tck,
   input  wire                   tck_reset_n,
   output logic [byte_width-1:0] tx_byte,
   output logic                  tx_pending, // byte waiting for a frame start
   input  wire                   tx_taken    // one tck pulse, byte loaded
);

   logic [byte_width-1:0] data_q; // byte held for the tck side
   logic                  req_q;  // toggles per accepted byte
   logic                  ack_q;  // tck copy, toggles per taken byte
   logic                  req_sync;
   logic                  ack_sync;
   logic                  accept;

   assign accept     = sink_valid & sink_ready;
   assign sink_ready = (req_q == ack_sync); // idle when toggles agree

   // clk side
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n)    req_q <= 1'b0;
      else if (accept) req_q <= ~req_q;
   end

   always_ff @(posedge clk) begin
      if (accept) data_q <= sink_data; // frozen until ack returns
   end

   bit_synchronizer #(.depth(req_sync_depth)) u_req_sync (
      .clk     (tck),
      .reset_n (tck_reset_n),
      .din     (req_q),
      .dout    (req_sync)
   );

   // tck side
   always_ff @(posedge tck or negedge tck_reset_n) begin
      if (!tck_reset_n)  ack_q <= 1'b0;
      else if (tx_taken) ack_q <= ~ack_q;
   end

   assign tx_pending = req_sync ^ ack_q;
   assign tx_byte    = data_q; // quiet while tx_pending is high

   bit_synchronizer #(.depth(ack_sync_depth)) u_ack_sync (
      .clk     (clk),
      .reset_n (reset_n),
      .din     (ack_q),
      .dout    (ack_sync)
   );

   // ack may only come back for a byte still outstanding
   a_ack_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
      $changed(ack_sync) |-> !$past(sink_ready));

endmodule : sink_crosser

`default_nettype wire

/* source_crosser.sv */
// tck to clk byte crosser
`default_nettype none

module source_crosser
   import jtag_bridge_pkg::*;
#(
   parameter int sync_depth = tck_to_clk_sync_depth
) (
   // tck side
   input  wire                   tck,
   input  wire                   tck_reset_n,
   input  wire  [byte_width-1:0] rx_byte,
   input  wire                   rx_strobe,   // one tck pulse per byte
   // clk side
   input  wire                   clk,
   input  wire                   reset_n,
   output logic [byte_width-1:0] source_data,
   output logic                  source_valid // one clk pulse per byte
);

   logic [byte_width-1:0] byte_hold;   // written in tck, read in clk
   logic                  strobe_flag; // toggles once per byte
   logic                  byte_arrived;

   // tck side holds the byte until the next strobe, 9 tck later at least
   always_ff @(posedge tck or negedge tck_reset_n) begin
      if (!tck_reset_n) strobe_flag <= 1'b0;
      else if (rx_strobe) strobe_flag <= ~strobe_flag;
   end

   always_ff @(posedge tck) begin
      if (rx_strobe) byte_hold <= rx_byte; // stable long before the flag lands in clk
   end

   // only the flag crosses; each toggle is one byte
   control_signal_crosser #(
      .sync_depth (sync_depth),
      .edge_mode  (edge_any)
   ) u_valid_crosser (
      .clk         (clk),
      .reset_n     (reset_n),
      .async_level (strobe_flag),
      .pulse       (byte_arrived)
   );

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) source_valid <= 1'b0;
      else          source_valid <= byte_arrived;
   end

   always_ff @(posedge clk) begin
      if (byte_arrived) source_data <= byte_hold; // holds until next byte
   end

   // serial rate keeps bytes far apart in clk
   a_valid_spaced: assert property (@(posedge clk) disable iff (!reset_n)
      source_valid |=> !source_valid);

endmodule : source_crosser

`default_nettype wire

/* control_signal_crosser.sv */
// level to pulse crosser
`default_nettype none

module control_signal_crosser
   import jtag_bridge_pkg::*;
#(
   parameter int sync_depth = tck_to_clk_sync_depth,
   parameter int edge_mode  = edge_rising // edge_rising, edge_falling or edge_any
) (
   input  wire  clk,
   input  wire  reset_n,
   input  wire  async_level, // level from the other clock domain
   output logic pulse        // one clk wide
);

   logic level_sync; // level after the synchronizer
   logic level_q;    // previous synchronized value

   bit_synchronizer #(.depth(sync_depth)) u_sync (
      .clk     (clk),
      .reset_n (reset_n),
      .din     (async_level),
      .dout    (level_sync)
   );

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) level_q <= 1'b0;
      else          level_q <= level_sync; // edge detector history
   end

   // pick the edge; toggles use edge_any
   always_comb begin
      case (edge_mode)
         edge_rising:  pulse = level_sync & ~level_q;
         edge_falling: pulse = ~level_sync & level_q;
         default:      pulse = level_sync ^ level_q;
      endcase
   end

   // source level must move slower than clk
   a_pulse_single: assert property (@(posedge clk) disable iff (!reset_n)
      pulse |=> !pulse);

endmodule : control_signal_crosser

`default_nettype wire

/* bit_synchronizer.sv */
// single bit synchronizer
`default_nettype none

module bit_synchronizer
   import jtag_bridge_pkg::*;
#(
   parameter int depth = tck_to_clk_sync_depth // number of flops, at least 2
) (
   input  wire  clk,
   input  wire  reset_n,
   input  wire  din,     // asynchronous to clk
   output logic dout
);

   logic [depth-1:0] sync_q; // sync_q[0] is the metastable stage

   // plain shift chain, cleared on reset
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[depth-2:0], din};
      end
   end

   assign dout = sync_q[depth-1]; // last stage is safe to use

endmodule : bit_synchronizer

`default_nettype wire

/* jtag_bridge_pkg.sv */
// jtag bridge shared definitions
`default_nettype none

package jtag_bridge_pkg;

   // payload and frame geometry
   localparam int byte_width      = 8;   // data byte size in bits
   localparam int frame_bits      = 9;   // flag bit + data bits, lsb first
   localparam int frame_cnt_width = $clog2(frame_bits); // shift position counter

   // synchronizer depths for each crossing direction
   localparam int tck_to_clk_sync_depth = 3; // stages into clk
   localparam int clk_to_tck_sync_depth = 2; // stages into tck

   // the only command byte; delivered as resetrequest, never as data
   localparam logic [byte_width-1:0] reset_cmd_byte = 8'hF5;

   // edge selection for control_signal_crosser
   localparam int edge_rising  = 0;
   localparam int edge_falling = 1;
   localparam int edge_any     = 2;

   // frame phase of the tck engine
   typedef enum logic {
      phase_flag, // shifting the valid flag bit
      phase_data  // shifting the data bits
   } frame_phase_t;

endpackage : jtag_bridge_pkg

`default_nettype wire
